/* verilog/dma_pkg.sv */
`default_nettype none

package dma_pkg;

  ////////////////////
  // Basic widths

  // Byte address on the memory side
  typedef logic [31:0] addr_t;
  // One data word, also the flit payload
  typedef logic [31:0] data_t;

  // Word step between consecutive data words
  localparam int ADDR_STEP = 4;

  ////////////////////
  // NoC flits

  // Position of a flit within its packet
  typedef enum logic [1:0] {
    FLIT_MIDDLE = 2'b00,
    FLIT_FIRST  = 2'b01,
    FLIT_LAST   = 2'b10,
    FLIT_SINGLE = 2'b11
  } flit_type_t;

  // Type sits in the two top bits, content below
  typedef struct packed {
    flit_type_t ftype;
    data_t      content;
  } flit_t;

  ////////////////////
  // Packet header

  // Packet kinds carried in the header content
  typedef enum logic [3:0] {
    PKT_L2R_RESP = 4'd2,
    PKT_R2L_RESP = 4'd3
  } pkt_type_t;

  // Field positions inside the header content word
  localparam int PKT_TYPE_LSB  = 20;
  localparam int PKT_TYPE_W    = $bits(pkt_type_t);
  localparam int PKT_RESP_LAST = 19;
  // Table entry id, low bits of the header
  localparam int PKT_ID_LSB    = 0;

  ////////////////////
  // AXI4-Lite write

  // Write address channel payload
  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } axil_aw_t;

  // Write data channel payload
  typedef struct packed {
    data_t      data;
    logic [3:0] strb;
  } axil_w_t;

  // Write response code
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t AXIL_OKAY   = 2'b00;
  localparam axil_resp_t AXIL_SLVERR = 2'b10;

  // Unprivileged, secure, data access
  localparam logic [2:0] AXIL_PROT_DATA = 3'b000;
  // Full word writes only
  localparam logic [3:0] AXIL_STRB_ALL  = 4'hf;

endpackage

`default_nettype wire

/* verilog/dma_packet_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

module dma_packet_buffer #(
  // Depth in flits, at least 2
  parameter int BUFFER_DEPTH = 16
) (
  input  logic           clk,
  input  logic           rst,

  // NoC side
  input  dma_pkg::flit_t in_flit,
  input  logic           in_valid,
  output logic           in_ready,

  // Handler side
  output dma_pkg::flit_t out_flit,
  output logic           out_valid,
  input  logic           out_ready
);

  import dma_pkg::*;

  localparam int PTR_W = $clog2(BUFFER_DEPTH);
  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

  ////////////////////
  // Storage and pointers

  flit_t            mem [BUFFER_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Full only when every slot is taken
  assign in_ready  = (count != CNT_W'(BUFFER_DEPTH));
  assign out_valid = (count != '0);
  // Head of the queue
  assign out_flit  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Flit storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  ////////////////////
  // Control state

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at the depth, which need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push with pop keeps occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/dma_resp_handler.sv */
`default_nettype none
`timescale 1ns/100ps

module dma_resp_handler #(
  parameter  int TABLE_ENTRIES = 4,
  localparam int ID_W          = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic                 clk,
  input  logic                 rst,

  // Flits from the packet buffer
  input  dma_pkg::flit_t       flit,
  input  logic                 flit_valid,
  output logic                 flit_ready,

  // AXI4-Lite write address
  output dma_pkg::axil_aw_t    awaddr,
  output logic                 awvalid,
  input  logic                 awready,

  // AXI4-Lite write data
  output dma_pkg::axil_w_t     wdata,
  output logic                 wvalid,
  input  logic                 wready,

  // AXI4-Lite write response
  input  dma_pkg::axil_resp_t  bresp,
  input  logic                 bvalid,
  output logic                 bready,

  // Completion towards the done tracker
  output logic                 done_en,
  output logic [ID_W-1:0]      done_id,
  output logic                 done_err
);

  import dma_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    GET_SIZE,
    GET_ADDR,
    DATA,
    WAIT_B
  } state_t;

  ////////////////////
  // Registers and decode

  state_t          state;
  state_t          state_next;
  logic [ID_W-1:0] resp_id;
  logic            resp_last;
  addr_t           resp_addr;
  // Sticky over the words of one transfer
  logic            err_acc;
  // Channel still waiting for its handshake
  logic            aw_pend;
  logic            w_pend;

  pkt_type_t       hdr_type;
  logic            is_header;
  logic            is_tail;
  logic            b_done;
  logic            resp_err;

  assign hdr_type  = pkt_type_t'(flit.content[PKT_TYPE_LSB +: PKT_TYPE_W]);
  // Only first or single flits start a packet
  assign is_header = (flit.ftype == FLIT_FIRST) || (flit.ftype == FLIT_SINGLE);
  // Last data word of the packet
  assign is_tail   = (flit.ftype == FLIT_LAST) || (flit.ftype == FLIT_SINGLE);
  assign b_done    = bvalid && bready;
  assign resp_err  = (bresp != AXIL_OKAY);

  // Write payload comes straight from the held head flit
  assign awaddr  = '{addr: resp_addr, prot: AXIL_PROT_DATA};
  assign wdata   = '{data: flit.content, strb: AXIL_STRB_ALL};
  assign awvalid = aw_pend;
  assign wvalid  = w_pend;
  // Accept the response once both requests are through
  assign bready  = (state == WAIT_B) && !aw_pend && !w_pend;

  ////////////////////
  // Next state and outputs

  always_comb begin
    state_next = state;
    flit_ready = 1'b0;
    done_en    = 1'b0;
    done_id    = resp_id;
    done_err   = 1'b0;

    case (state)
      IDLE: begin
        // Stray body flits of dropped packets are eaten here too
        flit_ready = 1'b1;
        if (flit_valid && is_header) begin
          case (hdr_type)
            PKT_L2R_RESP: begin
              // Acknowledge only, completes right away
              done_en = 1'b1;
              done_id = flit.content[PKT_ID_LSB +: ID_W];
            end
            PKT_R2L_RESP: begin
              state_next = GET_SIZE;
            end
            default: begin
              // Unknown kind is dropped
              state_next = IDLE;
            end
          endcase
        end
      end
      GET_SIZE: begin
        // Size is implied by the tail flit
        flit_ready = 1'b1;
        if (flit_valid) begin
          state_next = GET_ADDR;
        end
      end
      GET_ADDR: begin
        flit_ready = 1'b1;
        if (flit_valid) begin
          state_next = DATA;
        end
      end
      DATA: begin
        if (flit_valid) begin
          state_next = WAIT_B;
        end
      end
      WAIT_B: begin
        // Word retires with its write response
        if (b_done) begin
          flit_ready = 1'b1;
          if (is_tail) begin
            state_next = IDLE;
            if (resp_last) begin
              done_en  = 1'b1;
              done_err = err_acc || resp_err;
            end
          end else begin
            state_next = DATA;
          end
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  ////////////////////
  // Control state

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      aw_pend   <= 1'b0;
      w_pend    <= 1'b0;
      err_acc   <= 1'b0;
      resp_last <= 1'b0;
    end else begin
      state <= state_next;
      // Both channels open together, each closes on its own handshake
      if ((state == DATA) && flit_valid) begin
        aw_pend <= 1'b1;
        w_pend  <= 1'b1;
      end else begin
        if (awready) begin
          aw_pend <= 1'b0;
        end
        if (wready) begin
          w_pend <= 1'b0;
        end
      end
      if ((state == IDLE) && flit_valid && is_header && (hdr_type == PKT_R2L_RESP)) begin
        resp_last <= flit.content[PKT_RESP_LAST];
      end
      // Error flag lives until the transfer reports done
      if (b_done) begin
        if (is_tail && resp_last) begin
          err_acc <= 1'b0;
        end else if (resp_err) begin
          err_acc <= 1'b1;
        end
      end
    end
  end

  // Transfer id and running address
  always_ff @(posedge clk) begin
    if ((state == IDLE) && flit_valid && is_header && (hdr_type == PKT_R2L_RESP)) begin
      resp_id <= flit.content[PKT_ID_LSB +: ID_W];
    end
    if ((state == GET_ADDR) && flit_valid) begin
      resp_addr <= flit.content;
    end else if (b_done) begin
      resp_addr <= resp_addr + addr_t'(ADDR_STEP);
    end
  end

endmodule

`default_nettype wire

/* verilog/dma_done_tracker.sv */
`default_nettype none
`timescale 1ns/100ps

module dma_done_tracker #(
  parameter  int TABLE_ENTRIES = 4,
  localparam int ID_W          = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic                     clk,
  input  logic                     rst,

  // Completion pulse from the handler
  input  logic                     done_en,
  input  logic [ID_W-1:0]          done_id,
  input  logic                     done_err,

  // Software side
  input  logic [TABLE_ENTRIES-1:0] clear,
  output logic [TABLE_ENTRIES-1:0] done,
  output logic [TABLE_ENTRIES-1:0] error
);

  ////////////////////
  // Set and clear

  // One-hot set from the pulse
  logic [TABLE_ENTRIES-1:0] set_vec;
  logic [TABLE_ENTRIES-1:0] done_keep;
  logic [TABLE_ENTRIES-1:0] err_keep;
  logic [TABLE_ENTRIES-1:0] done_next;
  logic [TABLE_ENTRIES-1:0] err_next;

  always_comb begin
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      // Ids beyond the table never match
      set_vec[i] = done_en && (done_id == ID_W'(i));
    end
  end

  // Flags that survive the software clear
  assign done_keep = done & ~clear;
  assign err_keep  = error & ~clear;

  // A set in the same cycle beats the clear
  assign done_next = done_keep | set_vec;
  // Error stays sticky until cleared
  assign err_next  = err_keep | (set_vec & {TABLE_ENTRIES{done_err}});

  ////////////////////
  // Flag registers

  always_ff @(posedge clk) begin
    if (rst) begin
      done  <= '0;
      error <= '0;
    end else begin
      done  <= done_next;
      error <= err_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/dma_initiator_resp.sv */
`default_nettype none
`timescale 1ns/100ps

module dma_initiator_resp #(
  parameter  int TABLE_ENTRIES = 4,
  parameter  int BUFFER_DEPTH  = 16
) (
  input  logic                     clk,
  input  logic                     rst,

  // NoC response input
  input  dma_pkg::flit_t           noc_flit,
  input  logic                     noc_valid,
  output logic                     noc_ready,

  // AXI4-Lite write port to local memory
  output dma_pkg::axil_aw_t        awaddr,
  output logic                     awvalid,
  input  logic                     awready,
  output dma_pkg::axil_w_t         wdata,
  output logic                     wvalid,
  input  logic                     wready,
  input  dma_pkg::axil_resp_t      bresp,
  input  logic                     bvalid,
  output logic                     bready,

  // Completion status for software
  input  logic [TABLE_ENTRIES-1:0] clear,
  output logic [TABLE_ENTRIES-1:0] done,
  output logic [TABLE_ENTRIES-1:0] error
);

  import dma_pkg::*;

  localparam int ID_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

  ////////////////////
  // Internal links

  // Buffer head towards the handler
  flit_t           buf_flit;
  logic            buf_valid;
  logic            buf_ready;

  // Handler completion pulse
  logic            done_en;
  logic [ID_W-1:0] done_id;
  logic            done_err;

  // Decouples the NoC from memory stalls
  dma_packet_buffer #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) i_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_flit  (noc_flit),
    .in_valid (noc_valid),
    .in_ready (noc_ready),
    .out_flit (buf_flit),
    .out_valid(buf_valid),
    .out_ready(buf_ready)
  );

  // Packet parser and memory writer
  dma_resp_handler #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) i_handler (
    .clk       (clk),
    .rst       (rst),
    .flit      (buf_flit),
    .flit_valid(buf_valid),
    .flit_ready(buf_ready),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .done_en   (done_en),
    .done_id   (done_id),
    .done_err  (done_err)
  );

  // Per-entry status flags
  dma_done_tracker #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) i_tracker (
    .clk     (clk),
    .rst     (rst),
    .done_en (done_en),
    .done_id (done_id),
    .done_err(done_err),
    .clear   (clear),
    .done    (done),
    .error   (error)
  );

endmodule

`default_nettype wire

/* tb/tb_axil_mem.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_axil_mem #(
  parameter dma_pkg::addr_t ERR_ADDR = 32'h0000_0300,
  parameter logic [31:0]    SEED     = 32'h0989fafb
) (
  input  logic                clk,
  input  logic                rst,
  input  dma_pkg::axil_aw_t   awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  dma_pkg::axil_w_t    wdata,
  input  logic                wvalid,
  output logic                wready,
  output dma_pkg::axil_resp_t bresp,
  output logic                bvalid,
  input  logic                bready,
  // Higher level means fewer ready cycles
  input  logic [1:0]          stall,
  output logic [31:0]         write_count
);

  import dma_pkg::*;

  // 1 KB of words, indexed by address bits 9:2
  data_t       mem [256];
  logic [31:0] rnd;
  logic        aw_got;
  logic        w_got;
  addr_t       wr_addr;
  data_t       wr_data;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Each channel takes one beat per write
  assign awready = !aw_got && (rnd[1:0] >= stall);
  assign wready  = !w_got && (rnd[3:2] >= stall);

  always @(posedge clk) begin
    if (rst) begin
      rnd         <= SEED;
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      bvalid      <= 1'b0;
      bresp       <= AXIL_OKAY;
      write_count <= '0;
      // Fill word tracks its own byte address
      for (int i = 0; i < 256; i++) begin
        mem[i] <= 32'hbad00000 | (i << 2);
      end
    end else begin
      rnd <= xorshift32(rnd);
      if (awvalid && awready) begin
        aw_got  <= 1'b1;
        wr_addr <= awaddr.addr;
      end
      if (wvalid && wready) begin
        w_got   <= 1'b1;
        wr_data <= wdata.data;
      end
      if (bvalid && bready) begin
        bvalid      <= 1'b0;
        aw_got      <= 1'b0;
        w_got       <= 1'b0;
        write_count <= write_count + 32'd1;
      end else if (aw_got && w_got && !bvalid && (rnd[5:4] >= stall)) begin
        bvalid <= 1'b1;
        // Error address rejects the write
        if (wr_addr == ERR_ADDR) begin
          bresp <= AXIL_SLVERR;
        end else begin
          bresp             <= AXIL_OKAY;
          mem[wr_addr[9:2]] <= wr_data;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_dma_initiator_resp.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_dma_initiator_resp;

  import dma_pkg::*;

  localparam int          TABLE_ENTRIES = 4;
  // Small buffer so that stalls overfill it
  localparam int          BUFFER_DEPTH  = 8;
  localparam int          PAT_MAX       = 128;
  localparam logic [31:0] SEED          = 32'h0989fafb;

  typedef logic [TABLE_ENTRIES-1:0] entry_vec_t;

  logic        clk;
  logic        rst;
  flit_t       noc_flit;
  logic        noc_valid;
  logic        noc_ready;
  axil_aw_t    awaddr;
  logic        awvalid;
  logic        awready;
  axil_w_t     wdata;
  logic        wvalid;
  logic        wready;
  axil_resp_t  bresp;
  logic        bvalid;
  logic        bready;
  entry_vec_t  clear;
  entry_vec_t  done;
  entry_vec_t  error;
  logic [1:0]  stall;
  logic [31:0] write_count;

  // Record is kind, a, b
  logic [71:0] pats [PAT_MAX];
  logic [31:0] rnd;
  int          errors;
  int          checks;
  int          flits;
  int          cycles;
  int          limit;
  // Set once a flit waits on a full buffer
  logic        saw_backpressure;

  dma_initiator_resp #(
    .TABLE_ENTRIES(TABLE_ENTRIES),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .noc_flit (noc_flit),
    .noc_valid(noc_valid),
    .noc_ready(noc_ready),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .clear    (clear),
    .done     (done),
    .error    (error)
  );

  tb_axil_mem #(
    .ERR_ADDR(32'h0000_0300),
    .SEED    (SEED)
  ) i_mem (
    .clk        (clk),
    .rst        (rst),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .stall      (stall),
    .write_count(write_count)
  );

  always #50 clk = ~clk;

  // Run limit from the flit count
  always @(posedge clk) begin
    cycles = cycles + 1;
    if ((limit != 0) && (cycles >= limit)) begin
      $display("Timeout after %0d cycles, the DUT did not finish the patterns", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////
  // Compare tasks

  task automatic check_word(input addr_t addr, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: memory word at %h is %h, expected %h", $time, addr, got, exp);
    end
  endtask

  task automatic check_done(input entry_vec_t got, input entry_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: done vector is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_error(input entry_vec_t got, input entry_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: error vector is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_count(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: memory write count is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_prot(input logic [2:0] got, input logic [2:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: write protection is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_strb(input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: write strobes are %b, expected %b", $time, got, exp);
    end
  endtask

  ////////////////////
  // Bus monitor

  // Unprivileged data access and full strobes on every beat
  always @(negedge clk) begin
    if (!rst && awvalid && awready) begin
      check_prot(awaddr.prot, 3'b000);
    end
    if (!rst && wvalid && wready) begin
      check_strb(wdata.strb, 4'hf);
    end
    // Sender held off by a full buffer
    if (!rst && noc_valid && !noc_ready) begin
      saw_backpressure = 1'b1;
    end
  end

  ////////////////////
  // Drivers

  // Starts and ends just after a rising edge
  task automatic send_flit(input flit_type_t ft, input data_t word);
    int   gap;
    logic taken;
    rnd = xorshift32(rnd);
    // Back to back while memory stalls
    gap = (stall == 2'd0) ? int'(rnd[1:0]) : 0;
    if (gap > 0) begin
      noc_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    noc_flit  <= '{ftype: ft, content: word};
    noc_valid <= 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = noc_ready;
      @(posedge clk);
    end
  endtask

  task automatic apply_clear(input entry_vec_t vec);
    clear <= vec;
    @(posedge clk);
    clear <= '0;
  endtask

  initial begin
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    int          idx;
    clk              = 1'b0;
    rst              = 1'b1;
    noc_flit         = '0;
    noc_valid        = 1'b0;
    clear            = '0;
    stall            = 2'd0;
    rnd              = SEED;
    errors           = 0;
    checks           = 0;
    flits            = 0;
    cycles           = 0;
    limit            = 0;
    saw_backpressure = 1'b0;
    for (int i = 0; i < PAT_MAX; i++) begin
      pats[i] = '0;
    end
    $readmemh("tb/dma_patterns.txt", pats);
    for (int i = 0; (i < PAT_MAX) && (pats[i][71:64] != 8'h00); i++) begin
      if (pats[i][71:64] == 8'h01) begin
        flits++;
      end
    end
    if (flits == 0) begin
      errors++;
      $display("The pattern file holds no flit records");
    end
    limit = 20 * flits + 2000;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    idx = 0;
    while ((idx < PAT_MAX) && (pats[idx][71:64] != 8'h00)) begin
      kind = pats[idx][71:64];
      a    = pats[idx][63:32];
      b    = pats[idx][31:0];
      if (kind != 8'h01) begin
        noc_valid <= 1'b0;
      end
      case (kind)
        8'h01: send_flit(flit_type_t'(a[1:0]), b);
        8'h02: apply_clear(b[TABLE_ENTRIES-1:0]);
        8'h03: begin
          @(negedge clk);
          check_word(a, i_mem.mem[a[9:2]], b);
          @(posedge clk);
        end
        8'h04: begin
          // Wait for the listed entries to finish
          do @(negedge clk); while ((done & b[TABLE_ENTRIES-1:0]) != b[TABLE_ENTRIES-1:0]);
          @(posedge clk);
        end
        8'h05: begin
          @(negedge clk);
          check_done(done, b[TABLE_ENTRIES-1:0]);
          @(posedge clk);
        end
        8'h06: begin
          @(negedge clk);
          check_error(error, b[TABLE_ENTRIES-1:0]);
          @(posedge clk);
        end
        8'h07: begin
          stall <= b[1:0];
          @(posedge clk);
        end
        8'h08: begin
          do @(negedge clk); while (write_count < b);
          @(posedge clk);
        end
        8'h09: begin
          @(negedge clk);
          check_count(write_count, b);
          @(posedge clk);
        end
        default: begin
          errors++;
          $display("Pattern record %0d has an unknown kind %h", idx, kind);
        end
      endcase
      idx++;
    end
    noc_valid <= 1'b0;

    // Heavy stalls are meant to fill the buffer
    if (!saw_backpressure) begin
      errors++;
      $display("The buffer never held off the NoC input during memory stalls");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
verilog/dma_pkg.sv
verilog/dma_packet_buffer.sv
verilog/dma_resp_handler.sv
verilog/dma_done_tracker.sv
verilog/dma_initiator_resp.sv
tb/tb_axil_mem.sv
tb/tb_dma_initiator_resp.sv

/* Makefile */
# Verilator build and run of the DMA initiator response testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       := tb_dma_initiator_resp
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/dma_patterns.txt */
// Columns: kind (2 hex digits), a (8), b (8), written without spaces
// Kinds: 01 flit a=type b=content, 02 clear b, 03 memory word a=addr b=data,
// 04 wait for done bits b, 05 done == b, 06 error == b, 07 memory stall level b,
// 08 wait for b completed writes, 09 write count == b, 00 end
// Flit types: 0 middle, 1 first, 2 last, 3 single
// Header content: type at bits 23:20, response-last at bit 19, entry id at bits 1:0
// Status after reset
050000000000000000
060000000000000000
// Entry 0, four words from 0x100
070000000000000001
010000000100380000
010000000000000004
010000000000000100
0100000000a0000000
0100000000a0000001
0100000000a0000002
0100000002a0000003
040000000000000001
0300000100a0000000
0300000104a0000001
0300000108a0000002
030000010ca0000003
// Entry 1, acknowledgement only
090000000000000004
010000000300200001
040000000000000002
090000000000000004
050000000000000003
060000000000000000
// Entry 2, split over two packets
010000000100300002
010000000000000002
010000000000000180
0100000000b0000000
0100000002b0000001
080000000000000006
050000000000000003
010000000100380002
010000000000000002
010000000000000188
0100000000b0000002
0100000002b0000003
040000000000000004
0300000180b0000000
030000018cb0000003
// Entry 3, second word hits the error address
010000000100380003
010000000000000002
0100000000000002fc
0100000000c0000000
0100000002c0000001
040000000000000008
03000002fcc0000000
060000000000000008
05000000000000000f
// Clear entries 0 and 3, then an unknown header and an ack for entry 0
020000000000000009
050000000000000006
060000000000000000
010000000300500003
010000000300200000
040000000000000001
09000000000000000a
050000000000000007
060000000000000000
// Heavy stalls with back to back packets
02000000000000000f
050000000000000000
070000000000000003
010000000100380001
010000000000000003
010000000000000200
0100000000d0000000
0100000000d0000001
0100000002d0000002
010000000100380002
010000000000000003
010000000000000240
0100000000e0000000
0100000000e0000001
0100000002e0000002
010000000300200003
04000000000000000e
0300000200d0000000
0300000204d0000001
0300000208d0000002
0300000240e0000000
0300000244e0000001
0300000248e0000002
060000000000000000
090000000000000010
000000000000000000
